/* all.f */
+incdir+testbench
verilog/spi_regs_pkg.sv
verilog/spi_frame_if.sv
verilog/spi_frame_slave.sv
verilog/register_bank.sv
verilog/peripheral_select.sv
verilog/spi_mux_top.sv
testbench/tb_spi_mux_top.sv

/* testbench/spi_master_tasks.svh */
//////////////////////////////
// spi master tasks, random source and error counters
// included inside the testbench module body
//////////////////////////////

`ifndef spi_master_tasks_svh
`define spi_master_tasks_svh

  // galois lfsr state, one step per bit taken
  logic [31:0] lfsr_state = 32'h8cff_1563;
  int error_count = 0;
  int check_count = 0;

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] result;
    logic        out_bit;
    result = '0;
    for (int i = 0; i < n; i++)
    begin
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      // feedback taps folded back in when a one falls out
      if (out_bit)
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      result = {result[30:0], out_bit};
    end
    return result;
  endfunction

  // every drive happens just after a falling cs edge
  task automatic wait_cycles(input int n);
    repeat (n) @(negedge cs);
  endtask

  task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
                             input string what);
    check_count++;
    assert (actual === expected)
    else
    begin
      error_count++;
      $display("FAIL %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  //////////////////////////////
  // frame level

  // mode 0, msb first, miso captured on each rising spi_clk
  task automatic shift_bits(input logic [15:0] word, input int nbits,
                            output logic [7:0] rx);
    rx = '0;
    wait_cycles(1);
    spi_ss = 1'b0;
    wait_cycles(half_period);
    for (int i = 0; i < nbits; i++)
    begin
      spi_mosi = word[15-i];
      wait_cycles(half_period);
      // clock and data reach the peripherals unchanged
      check_value(periph_mosi, word[15-i], "periph_mosi pass-through");
      check_value(periph_clk, 1'b0, "periph_clk pass-through, low phase");
      spi_clk = 1'b1;
      // read data lives in bits 9 to 16
      if (i >= 8)
        rx = {rx[6:0], spi_miso};
      wait_cycles(half_period);
      check_value(periph_clk, 1'b1, "periph_clk pass-through, high phase");
      spi_clk = 1'b0;
    end
    wait_cycles(half_period);
    spi_ss   = 1'b1;
    spi_mosi = 1'b0;
    // covers synchronizer, frame strobe and register update
    wait_cycles(frame_gap);
  endtask

  task automatic spi_frame(input logic [7:0] addr, input logic [7:0] data,
                           output logic [7:0] rx);
    shift_bits({addr, data}, 16, rx);
  endtask

  // chip select released after 10 bits
  task automatic aborted_frame(input logic [7:0] addr, input logic [7:0] data);
    logic [7:0] rx;
    shift_bits({addr, data}, 10, rx);
  endtask

`endif

/* testbench/tb_spi_mux_top.sv */
//////////////////////////////
// testbench for the spi register and select fabric
// spi frames from the master tasks, checked against a register model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_spi_mux_top;
  import spi_regs_pkg::*;

  localparam int half_period    = 6;
  localparam int frame_gap      = 8;
  // about 60 frames of 200 cycles
  localparam int timeout_cycles = 12000;
  localparam logic [7:0] sel_polarity = 8'b0111_0000;

  logic       cs;
  logic       reset;
  logic       spi_clk;
  logic       spi_ss;
  logic       spi_mosi;
  logic       spi_ss2;
  logic       spi_miso;
  logic [7:0] periph_miso;
  logic [7:0] periph_sel;
  logic       periph_clk;
  logic       periph_mosi;
  logic [3:0] led;
  logic [3:0] oe_4094;
  logic [3:0] adc_ctl;

  // register model
  logic [3:0] model_led;
  logic [7:0] model_mux;
  logic [3:0] model_4094;
  logic [3:0] model_adc;
  // update kinds seen
  logic saw_set;
  logic saw_clear;
  logic saw_toggle;
  int   cycle_count;

  `include "spi_master_tasks.svh"

  spi_mux_top #(
    .sel_count    (8),
    .sel_polarity (sel_polarity),
    .sync_stages  (2)
  ) dut_i (
    .cs          (cs),
    .reset       (reset),
    .spi_clk     (spi_clk),
    .spi_ss      (spi_ss),
    .spi_mosi    (spi_mosi),
    .spi_ss2     (spi_ss2),
    .spi_miso    (spi_miso),
    .periph_miso (periph_miso),
    .periph_sel  (periph_sel),
    .periph_clk  (periph_clk),
    .periph_mosi (periph_mosi),
    .led         (led),
    .oe_4094     (oe_4094),
    .adc_ctl     (adc_ctl)
  );

  //////////////////////////////
  // model rules

  // per bit: low nibble sets, high nibble clears, both means flip
  function automatic logic [3:0] nibble_rule(input logic [3:0] cur, input logic [7:0] d);
    logic [3:0] result;
    result = cur;
    for (int i = 0; i < 4; i++)
    begin
      if (d[i] && d[i+4])
      begin
        result[i] = ~cur[i];
        saw_toggle = 1'b1;
      end
      else if (d[i])
      begin
        result[i] = 1'b1;
        saw_set = 1'b1;
      end
      else if (d[i+4])
      begin
        result[i] = 1'b0;
        saw_clear = 1'b1;
      end
    end
    return result;
  endfunction

  task automatic model_write(input logic [7:0] addr, input logic [7:0] data);
    case (addr)
      addr_led:        model_led  = nibble_rule(model_led, data);
      addr_4094:       model_4094 = nibble_rule(model_4094, data);
      addr_adc:        model_adc  = nibble_rule(model_adc, data);
      addr_spi_mux:    model_mux  = data;
      addr_soft_reset:
      begin
        model_led = '0;
        model_mux = '0;
        model_adc = '0;
      end
      addr_powerup:
      begin
        model_led = '0;
        model_adc = '0;
      end
      default:
      begin
      end
    endcase
  endtask

  function automatic logic [7:0] read_value(input logic [7:0] addr);
    case (addr)
      addr_led:     return {4'b0, model_led};
      addr_spi_mux: return model_mux;
      addr_4094:    return {4'b0, model_4094};
      addr_adc:     return {4'b0, model_adc};
      default:      return 8'h00;
    endcase
  endfunction

  // lane n-1 active for mux value n while ss2 is low
  function automatic logic [7:0] expected_sel(input logic [7:0] mux, input logic ss2);
    logic [7:0] sel;
    for (int i = 0; i < 8; i++)
    begin
      if (!ss2 && mux == 8'(i + 1))
        sel[i] = sel_polarity[i];
      else
        sel[i] = ~sel_polarity[i];
    end
    return sel;
  endfunction

  //////////////////////////////
  // check helpers

  task automatic compare_outputs(input string when);
    check_value(led, model_led, {"led pins ", when});
    check_value(oe_4094, model_4094, {"oe_4094 pins ", when});
    check_value(adc_ctl, model_adc, {"adc_ctl pins ", when});
    check_value(periph_sel, expected_sel(model_mux, spi_ss2), {"periph_sel ", when});
  endtask

  // mux frames carry the current value so the read is harmless
  task automatic read_check(input logic [7:0] addr);
    logic [7:0] data;
    logic [7:0] expected;
    logic [7:0] rx;
    data     = (addr == addr_spi_mux) ? model_mux : 8'h00;
    expected = read_value(addr);
    spi_frame(addr, data, rx);
    model_write(addr, data);
    check_value(rx, expected, $sformatf("read back of address %0d", addr));
  endtask

  task automatic write_frame(input logic [7:0] addr, input logic [7:0] data);
    logic [7:0] rx;
    spi_frame(addr, data, rx);
    model_write(addr, data);
    compare_outputs($sformatf("after write %h to address %0d", data, addr));
  endtask

  //////////////////////////////
  // clock and timeout

  initial
  begin
    cs = 1'b0;
    forever #10 cs = ~cs;
  end

  initial
  begin : watchdog
    cycle_count = 0;
    while (cycle_count < timeout_cycles)
    begin
      @(posedge cs);
      cycle_count++;
    end
    $display("timeout: run still going after %0d cycles", timeout_cycles);
    $display("checks: %0d, errors: %0d", check_count, error_count + 1);
    $display("Test failures found");
    $finish;
  end

  //////////////////////////////
  // stimulus

  initial
  begin : stimulus
    logic [7:0] addr;
    logic [7:0] data;
    logic [1:0] pick;
    reset       = 1'b1;
    spi_clk     = 1'b0;
    spi_ss      = 1'b1;
    spi_mosi    = 1'b0;
    spi_ss2     = 1'b1;
    periph_miso = '0;
    model_led   = led_reset_value;
    model_mux   = '0;
    model_4094  = '0;
    model_adc   = '0;
    saw_set     = 1'b0;
    saw_clear   = 1'b0;
    saw_toggle  = 1'b0;
    repeat (2) @(negedge cs);
    reset = 1'b0;
    wait_cycles(2);

    // reset values, selects idle
    compare_outputs("after reset");
    read_check(addr_led);
    read_check(addr_4094);
    read_check(addr_adc);
    read_check(addr_spi_mux);

    // random nibble writes, set, clear and toggle all come from here
    repeat (10)
    begin
      pick = random_bits(2);
      addr = (pick == 2'd0) ? addr_led : (pick == 2'd1) ? addr_4094 : addr_adc;
      data = random_bits(8);
      write_frame(addr, data);
      read_check(addr);
    end

    // every mux value with the second select low
    spi_ss2 = 1'b0;
    for (int v = 0; v < 10; v++)
    begin
      write_frame(addr_spi_mux, 8'(v));
    end

    // miso follows the selected lane only
    for (int k = 0; k < 2; k++)
    begin
      write_frame(addr_spi_mux, (k == 0) ? 8'd3 : 8'd8);
      repeat (8)
      begin
        periph_miso = random_bits(8);
        wait_cycles(1);
        check_value(spi_miso, periph_miso[model_mux-1], "spi_miso from selected lane");
      end
    end
    spi_ss2     = 1'b1;
    periph_miso = '0;
    read_check(addr_spi_mux);
    read_check(addr_led);

    // soft reset keeps 4094
    write_frame(addr_led, 8'h0f);
    write_frame(addr_4094, 8'h05);
    write_frame(addr_adc, 8'h0a);
    write_frame(addr_spi_mux, 8'd5);
    write_frame(addr_soft_reset, random_bits(8));
    read_check(addr_spi_mux);
    // power-up keeps the mux
    write_frame(addr_led, 8'h03);
    write_frame(addr_adc, 8'h0c);
    write_frame(addr_spi_mux, 8'd4);
    write_frame(addr_powerup, random_bits(8));
    read_check(addr_spi_mux);

    // short frame and unknown address change nothing
    aborted_frame(addr_led, 8'h0f);
    compare_outputs("after aborted frame");
    write_frame(8'h20, 8'hff);
    read_check(addr_spi_mux);

    check_count++;
    assert (saw_set && saw_clear && saw_toggle)
    else
    begin
      error_count++;
      $display("not every set, clear and toggle case was exercised");
    end

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/spi_mux_top.sv */
//////////////////////////////
// top level of the spi register and select fabric
// spi_ss talks to the bank, spi_ss2 to the chosen peripheral
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spi_mux_top #(
  parameter int                   sel_count    = 8,
  parameter logic [sel_count-1:0] sel_polarity = 8'b0111_0000,
  parameter int                   sync_stages  = 2
) (
  input  wire                             cs,
  input  wire                             reset,
  // mcu spi port
  input  wire                             spi_clk,
  input  wire                             spi_ss,
  input  wire                             spi_mosi,
  input  wire                             spi_ss2,
  output logic                            spi_miso,
  // peripheral side
  input  wire  [sel_count-1:0]            periph_miso,
  output logic [sel_count-1:0]            periph_sel,
  output logic                            periph_clk,
  output logic                            periph_mosi,
  // register outputs
  output logic [spi_regs_pkg::ctl_w-1:0]  led,
  output logic [spi_regs_pkg::ctl_w-1:0]  oe_4094,
  output logic [spi_regs_pkg::ctl_w-1:0]  adc_ctl
);
  import spi_regs_pkg::*;

  logic              dout;
  logic [data_w-1:0] reg_spi_mux;

  spi_frame_if frm_if ();

  //////////////////////////////
  // spi pass-through

  // clock and data fan out unmuxed, only selects are gated
  assign periph_clk  = spi_clk;
  assign periph_mosi = spi_mosi;

  //////////////////////////////
  // bank access

  spi_frame_slave #(
    .sync_stages (sync_stages)
  ) slave_i (
    .cs       (cs),
    .reset    (reset),
    .spi_clk  (spi_clk),
    .spi_ss   (spi_ss),
    .spi_mosi (spi_mosi),
    .dout     (dout),
    .frm      (frm_if.slave)
  );

  register_bank bank_i (
    .cs          (cs),
    .reset       (reset),
    .frm         (frm_if.bank),
    .reg_led     (led),
    .reg_spi_mux (reg_spi_mux),
    .reg_4094    (oe_4094),
    .reg_adc     (adc_ctl)
  );

  //////////////////////////////
  // peripheral routing

  // mux register drives the select fabric directly
  peripheral_select #(
    .sel_count    (sel_count),
    .sel_polarity (sel_polarity)
  ) psel_i (
    .reg_spi_mux (reg_spi_mux),
    .spi_ss2     (spi_ss2),
    .dout        (dout),
    .periph_miso (periph_miso),
    .periph_sel  (periph_sel),
    .spi_miso    (spi_miso)
  );

endmodule

`default_nettype wire

/* verilog/peripheral_select.sv */
//////////////////////////////
// peripheral chip select fabric
// mux register picks a lane, spi_ss2 enables it, miso comes back
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module peripheral_select #(
  parameter int                  sel_count    = 8,
  parameter logic [sel_count-1:0] sel_polarity = 8'b0111_0000
) (
  input  wire  [spi_regs_pkg::data_w-1:0] reg_spi_mux,
  input  wire                             spi_ss2,
  input  wire                             dout,
  input  wire  [sel_count-1:0]            periph_miso,
  output logic [sel_count-1:0]            periph_sel,
  output logic                            spi_miso
);
  import spi_regs_pkg::*;

  logic [sel_count-1:0] lane_hit;
  logic [sel_count-1:0] lane_active;

  //////////////////////////////
  // lane decode

  // value n picks lane n-1
  // zero and anything past sel_count pick nothing
  always_comb
  begin
    for (int i = 0; i < sel_count; i++)
    begin
      lane_hit[i] = (reg_spi_mux == data_w'(i + 1));
    end
  end

  // ss2 is active low
  assign lane_active = lane_hit & {sel_count{~spi_ss2}};

  //////////////////////////////
  // select lines

  // idle lanes sit at ~polarity, the active lane drives polarity
  assign periph_sel = ~(lane_active ^ sel_polarity);

  //////////////////////////////
  // miso return

  // ss2 high means the mcu is talking to the bank itself
  always_comb
  begin
    if (spi_ss2)
      spi_miso = dout;
    else
      spi_miso = |(lane_hit & periph_miso);
  end

endmodule

`default_nettype wire

/* verilog/register_bank.sv */
//////////////////////////////
// control register bank
// set/clear/toggle nibble writes, commands and read lookup
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module register_bank (
  input  wire  cs,
  input  wire  reset,
  spi_frame_if.bank frm,
  output logic [spi_regs_pkg::ctl_w-1:0]  reg_led,
  output logic [spi_regs_pkg::data_w-1:0] reg_spi_mux,
  output logic [spi_regs_pkg::ctl_w-1:0]  reg_4094,
  output logic [spi_regs_pkg::ctl_w-1:0]  reg_adc
);
  import spi_regs_pkg::*;

  reg_addr_e wr_addr;
  reg_addr_e rd_addr;

  //////////////////////////////
  // nibble update rule

  // low nibble sets, high nibble clears
  // a bit named in both nibbles flips
  function automatic logic [ctl_w-1:0] nibble_update(
    input logic [ctl_w-1:0]  cur,
    input logic [data_w-1:0] val
  );
    logic [ctl_w-1:0] set_bits;
    logic [ctl_w-1:0] clr_bits;
    logic [ctl_w-1:0] tog_bits;
    set_bits = val[ctl_w-1:0];
    clr_bits = val[2*ctl_w-1:ctl_w];
    tog_bits = set_bits & clr_bits;
    // toggle bits drop out of both masks, then flip
    nibble_update = ((cur | (set_bits & ~tog_bits)) & ~(clr_bits & ~tog_bits)) ^ tog_bits;
  endfunction

  //////////////////////////////
  // write and command decode

  assign wr_addr = reg_addr_e'(frm.frame_addr);

  always_ff @(posedge cs)
  begin
    if (reset)
    begin
      reg_led     <= led_reset_value;
      reg_spi_mux <= '0;
      reg_4094    <= '0;
      reg_adc     <= '0;
    end
    else if (frm.frame_valid)
    begin
      case (wr_addr)
        addr_led:
          reg_led <= nibble_update(reg_led, frm.frame_data);
        addr_4094:
          reg_4094 <= nibble_update(reg_4094, frm.frame_data);
        addr_adc:
          reg_adc <= nibble_update(reg_adc, frm.frame_data);
        // mux is a whole byte, written as is
        addr_spi_mux:
          reg_spi_mux <= frm.frame_data;
        // data byte ignored for both commands
        addr_soft_reset:
        begin
          reg_led     <= '0;
          reg_spi_mux <= '0;
          reg_adc     <= '0;
          // 4094 output enables survive a soft reset
        end
        addr_powerup:
        begin
          // rails coming up, mux stays where it is
          reg_led <= '0;
          reg_adc <= '0;
        end
        default:
        begin
          // unknown address, nothing changes
        end
      endcase
    end
  end

  //////////////////////////////
  // read lookup

  // purely combinational, slave latches it with read_strobe
  assign rd_addr = reg_addr_e'(frm.read_addr);

  always_comb
  begin
    case (rd_addr)
      addr_led:
        frm.read_data = {{(data_w - ctl_w){1'b0}}, reg_led};
      addr_spi_mux:
        frm.read_data = reg_spi_mux;
      addr_4094:
        frm.read_data = {{(data_w - ctl_w){1'b0}}, reg_4094};
      addr_adc:
        frm.read_data = {{(data_w - ctl_w){1'b0}}, reg_adc};
      // commands and holes read as zero
      default:
        frm.read_data = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/spi_frame_slave.sv */
//////////////////////////////
// oversampled spi mode 0 slave
// builds 16 bit frames and shifts read data back out
// all pins resampled on cs, nothing clocked by spi_clk
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spi_frame_slave #(
  parameter int sync_stages = 2
) (
  input  wire  cs,
  input  wire  reset,
  input  wire  spi_clk,
  input  wire  spi_ss,
  input  wire  spi_mosi,
  output logic dout,
  spi_frame_if.slave frm
);
  import spi_regs_pkg::*;

  // one spare bit so an overlong frame never wraps back to 16
  localparam int cnt_w = $clog2(frame_bits) + 1;

  logic [sync_stages-1:0] clk_sync;
  logic [sync_stages-1:0] ss_sync;
  logic [sync_stages-1:0] mosi_sync;
  logic clk_s;
  logic ss_s;
  logic mosi_s;
  logic clk_d;
  logic ss_d;
  logic clk_rise;
  logic clk_fall;
  logic ss_rise;
  logic [cnt_w-1:0]      bit_count;
  logic [frame_bits-1:0] shift_reg;
  logic [data_w-1:0]     tx_shift;

  //////////////////////////////
  // pin synchronizers

  // ss idles high, so start the chain there
  always_ff @(posedge cs)
  begin
    if (reset)
    begin
      clk_sync <= '0;
      ss_sync  <= '1;
    end
    else
    begin
      clk_sync <= {clk_sync[sync_stages-2:0], spi_clk};
      ss_sync  <= {ss_sync[sync_stages-2:0], spi_ss};
    end
  end

  // data line only matters at a sampled edge
  always_ff @(posedge cs)
  begin
    mosi_sync <= {mosi_sync[sync_stages-2:0], spi_mosi};
  end

  assign clk_s  = clk_sync[sync_stages-1];
  assign ss_s   = ss_sync[sync_stages-1];
  assign mosi_s = mosi_sync[sync_stages-1];

  // edge detect against last cycle
  assign clk_rise = clk_s & ~clk_d;
  assign clk_fall = ~clk_s & clk_d;
  assign ss_rise  = ss_s & ~ss_d;

  //////////////////////////////
  // receive path

  // shift in on rising spi_clk while selected
  always_ff @(posedge cs)
  begin
    if (!ss_s && clk_rise)
      shift_reg <= {shift_reg[frame_bits-2:0], mosi_s};
  end

  // 8th bit is being sampled right now
  assign frm.read_strobe = ~ss_s & clk_rise & (bit_count == cnt_w'(addr_w - 1));
  // address byte including the bit on the wire this cycle
  assign frm.read_addr   = {shift_reg[addr_w-2:0], mosi_s};

  // frame fields are only looked at during frame_valid
  assign frm.frame_addr = shift_reg[frame_bits-1:data_w];
  assign frm.frame_data = shift_reg[data_w-1:0];

  //////////////////////////////
  // count, strobes and transmit path

  always_ff @(posedge cs)
  begin
    if (reset)
    begin
      clk_d           <= 1'b0;
      ss_d            <= 1'b1;
      bit_count       <= '0;
      tx_shift        <= '0;
      dout            <= 1'b0;
      frm.frame_valid <= 1'b0;
    end
    else
    begin
      clk_d <= clk_s;
      ss_d  <= ss_s;
      // count still holds the final total on the ss rising edge
      frm.frame_valid <= ss_rise && (bit_count == cnt_w'(frame_bits));
      if (ss_s)
      begin
        // deselected, drop any partial frame
        bit_count <= '0;
        tx_shift  <= '0;
        dout      <= 1'b0;
      end
      else if (clk_rise)
      begin
        // saturate rather than wrap
        if (bit_count != '1)
          bit_count <= bit_count + 1'b1;
        // lookup result lands with the 8th bit
        if (frm.read_strobe)
          tx_shift <= frm.read_data;
      end
      else if (clk_fall)
      begin
        // msb first, master picks it up on the next rise
        dout     <= tx_shift[data_w-1];
        tx_shift <= {tx_shift[data_w-2:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/spi_frame_if.sv */
//////////////////////////////
// frame and read-lookup channel
// between the spi slave and the register bank
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface spi_frame_if;
  import spi_regs_pkg::*;

  // completed 16 bit frame, one cycle strobe
  logic              frame_valid;
  logic [addr_w-1:0] frame_addr;
  logic [data_w-1:0] frame_data;

  // address byte just in, bank answers same cycle
  logic              read_strobe;
  logic [addr_w-1:0] read_addr;
  logic [data_w-1:0] read_data;

  modport slave (
    output frame_valid, frame_addr, frame_data, read_strobe, read_addr,
    input  read_data
  );

  // bank sees the lookup address continuously
  modport bank (
    input  frame_valid, frame_addr, frame_data, read_addr,
    output read_data
  );

endinterface

`default_nettype wire

/* verilog/spi_regs_pkg.sv */
//////////////////////////////
// shared constants for the spi register bank
// addresses, field widths and reset values, imported by the rtl
//////////////////////////////

`default_nettype none

package spi_regs_pkg;

  //////////////////////////////
  // frame layout

  // address byte, first on the wire
  localparam int addr_w = 8;
  // data byte, second on the wire
  localparam int data_w = 8;
  // control regs only use a nibble
  localparam int ctl_w = 4;
  // msb first, address then data
  localparam int frame_bits = addr_w + data_w;

  //////////////////////////////
  // register map

  // plain registers and the two data-less commands share one space
  typedef enum logic [addr_w-1:0] {
    // clears led and adc, mux untouched
    addr_powerup    = 8'd6,
    addr_led        = 8'd7,
    addr_spi_mux    = 8'd8,
    // output enables for the 4094 chain
    addr_4094       = 8'd9,
    // clears everything except 4094
    addr_soft_reset = 8'd11,
    addr_adc        = 8'd14
  } reg_addr_e;

  //////////////////////////////
  // reset values

  // one led lit out of reset
  localparam logic [ctl_w-1:0] led_reset_value = 4'b0001;

endpackage

`default_nettype wire
